// ==== aud_mix_chan.sv ====
// Single channel audio mixer pipeline
module aud_mix_chan
	import audio_pkg::*;
	import sys_cfg_pkg::*;
(
	input  logic     clk,
	input  logic     resetd,
	input  logic     i_advance,

	input  sample_t  i_core,
	input  logic     i_signed,
	input  sample_t  i_linux,
	input  sample_t  i_pre,
	input  mix_cfg_t i_cfg,

	output sample_t  o_pre,
	output sample_t  o_out
);

	acc_t st1;
	acc_t st2;
	acc_t st3;
	acc_t st4;
	acc_t pre_ext;
	acc_t linux_ext;
	acc_t core_ext;
	acc_t mixed;

	// Unsigned core audio is halved so it fits the signed range
	assign core_ext  = i_signed ? {i_core[15], i_core} : {2'b00, i_core[15:1]};
	assign linux_ext = {i_linux[15], i_linux};
	assign pre_ext   = {i_pre[15], i_pre};

	// Half of the sum, fed to the opposite channel
	assign o_pre = st2[16:1];

	//////////////////////////////////////////////////////////////
	// Cross-feed by mode
	//////////////////////////////////////////////////////////////

	always_comb begin
		case (i_cfg.mode)
			MIX_LOW:  mixed = st2 - (st2 >>> 3) + (pre_ext >>> 2);
			MIX_MID:  mixed = st2 - (st2 >>> 2) + (pre_ext >>> 1);
			MIX_MONO: mixed = (st2 >>> 1) + pre_ext;
			default:  mixed = st2;
		endcase
	end

	//////////////////////////////////////////////////////////////
	// Pipeline stages
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			st1   <= '0;
			st2   <= '0;
			st3   <= '0;
			st4   <= '0;
			o_out <= '0;
		end else if (i_advance) begin
			st1 <= core_ext;
			st2 <= st1 + linux_ext;
			st3 <= mixed;

			// Mute or volume shift
			if (i_cfg.att[4])
				st4 <= '0;
			else
				st4 <= st3 >>> i_cfg.att[3:0];

			// Saturate to 16-bit signed
			if (st4[16] != st4[15])
				o_out <= {st4[16], {15{st4[15]}}};
			else
				o_out <= st4[15:0];
		end
	end

endmodule

// ==== audio_pkg.sv ====
// Audio sample and mixer types
package audio_pkg;

	//////////////////////////////////////////////////////////////
	// Sample and accumulator widths
	//////////////////////////////////////////////////////////////

	// Raw 16-bit sample, signedness depends on the source
	typedef logic [15:0] sample_t;

	// One guard bit above a sample for sums
	typedef logic signed [16:0] acc_t;

	//////////////////////////////////////////////////////////////
	// Mixer controls and payloads
	//////////////////////////////////////////////////////////////

	// Amount of cross-feed between left and right
	typedef enum logic [1:0] {
		MIX_NONE,
		MIX_LOW,
		MIX_MID,
		MIX_MONO
	} mix_mode_t;

	// Stereo pair as delivered by the core
	typedef struct packed {
		sample_t left;
		sample_t right;
	} core_audio_t;

	// Stereo pair after mixing
	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

endpackage

// ==== audio_stream_if.sv ====
// Stereo sample stream
interface audio_stream_if import audio_pkg::*; ();

	// Transfer happens when valid and ready are both high
	logic    valid;
	logic    ready;
	sample_t left;
	sample_t right;

	// Producer side, holds valid and data while stalled
	modport src (
		output valid, left, right,
		input  ready
	);

	// Consumer side
	modport sink (
		input  valid, left, right,
		output ready
	);

endinterface

// ==== host_cmd_regs.sv ====
// Host command decoder
module host_cmd_regs
	import audio_pkg::*;
	import sys_cfg_pkg::*;
(
	input  logic       clk,
	input  logic       resetd,

	// Host bus
	input  logic       i_sel,
	input  logic       i_strobe,
	input  host_word_t i_data,

	// Configuration
	output mix_cfg_t   o_mix_cfg,
	output led_byte_t  o_led_mask,
	output led_byte_t  o_led_state
);

	//////////////////////////////////////////////////////////////
	// Frame tracking
	//////////////////////////////////////////////////////////////

	logic       has_cmd;
	logic [7:0] cmd;

	// First strobe in a frame is the command byte
	always_ff @(posedge clk) begin
		if (resetd) begin
			has_cmd <= 1'b0;
			cmd     <= '0;
		end else if (!i_sel) begin
			has_cmd <= 1'b0;
			cmd     <= '0;
		end else if (i_strobe && !has_cmd) begin
			has_cmd <= 1'b1;
			cmd     <= i_data[7:0];
		end
	end

	//////////////////////////////////////////////////////////////
	// Data word decode
	//////////////////////////////////////////////////////////////

	logic data_wr;
	logic led_wr;
	logic vol_wr;

	// Data strobes only count once a command is held
	assign data_wr = i_sel && i_strobe && has_cmd;
	assign led_wr  = data_wr && (cmd == CMD_LED);
	assign vol_wr  = data_wr && (cmd == CMD_VOLUME);

	// Mask in the high byte, state in the low byte
	always_ff @(posedge clk) begin
		if (resetd) begin
			o_led_mask  <= '0;
			o_led_state <= '0;
		end else if (led_wr) begin
			o_led_mask  <= i_data[15:8];
			o_led_state <= i_data[7:0];
		end
	end

	// Attenuation in bits 4:0, mix mode in bits 9:8
	always_ff @(posedge clk) begin
		if (resetd) begin
			o_mix_cfg.att  <= '0;
			o_mix_cfg.mode <= MIX_NONE;
		end else if (vol_wr) begin
			o_mix_cfg.att  <= i_data[4:0];
			o_mix_cfg.mode <= mix_mode_t'(i_data[9:8]);
		end
	end

endmodule

// ==== led_compositor.sv ====
// Main board LED compositor
module led_compositor
	import sys_cfg_pkg::*;
(
	input  logic        clk,
	input  logic        resetd,
	input  led_status_t i_status,
	input  led_byte_t   i_mask,
	input  led_byte_t   i_state,
	output led_byte_t   o_led
);

	logic      led_pwr;
	led_byte_t pattern;

	// Power LED is on unless the core takes control of it
	assign led_pwr = i_status.led_power[1] ? i_status.led_power[0] : 1'b1;

	// Fixed bit positions on the board
	always_comb begin
		pattern    = '0;
		pattern[6] = i_status.pll_locked;
		pattern[4] = led_pwr;
		pattern[2] = i_status.led_disk[0];
		pattern[0] = i_status.led_user;
	end

	//////////////////////////////////////////////////////////////
	// Host override merge
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd)
			o_led <= '0;
		else
			o_led <= (i_mask & i_state) | (~i_mask & pattern);
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run the testbench and scan the log for the pass line
verilator --binary --timing --top-module tb_sys_io_top -f src.f -o tb_sim > build.log 2>&1 \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { cat build.log; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "ALL CHECKS PASSED" sim.log && exit 0 || exit 1

// ==== src.f ====
audio_pkg.sv
sys_cfg_pkg.sv
audio_stream_if.sv
stable_filter.sv
host_cmd_regs.sv
led_compositor.sv
aud_mix_chan.sv
stereo_mixer.sv
sys_io_top.sv
tb_sys_io_top.sv

// ==== stable_filter.sv ====
// Settling filter for asynchronous inputs
module stable_filter #(
	parameter type T            = logic [15:0],
	parameter int  FILTER_DEPTH = 2
) (
	input  logic clk,
	input  logic resetd,
	input  T     i_value,
	output T     o_value
);

	// Capture register followed by FILTER_DEPTH compare taps
	T     chain [0:FILTER_DEPTH];
	logic agree;

	always_ff @(posedge clk) begin
		chain[0] <= i_value;
		for (int k = 1; k <= FILTER_DEPTH; k++) begin
			chain[k] <= chain[k-1];
		end
	end

	// All taps past the capture stage hold the same value
	always_comb begin
		agree = 1'b1;
		for (int k = 1; k < FILTER_DEPTH; k++) begin
			if (chain[k] != chain[FILTER_DEPTH])
				agree = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (resetd)
			o_value <= '0;
		else if (agree)
			o_value <= chain[FILTER_DEPTH];
	end

endmodule

// ==== stereo_mixer.sv ====
// Stereo mixer with output stream
module stereo_mixer
	import audio_pkg::*;
	import sys_cfg_pkg::*;
(
	input  logic           clk,
	input  logic           resetd,

	input  core_audio_t    i_core,
	input  logic           i_signed,
	input  sample_t        i_linux_l,
	input  sample_t        i_linux_r,
	input  mix_cfg_t       i_cfg,

	audio_stream_if.src    o_stream
);

	// One valid bit per stage, bit 0 is stage 1
	logic [4:0] stage_vld;
	logic       advance;
	sample_t    pre_l;
	sample_t    pre_r;
	sample_t    out_l;
	sample_t    out_r;
	stereo_t    out_smp;

	// Whole pipeline moves unless the output is held
	assign advance = !stage_vld[4] || o_stream.ready;

	always_ff @(posedge clk) begin
		if (resetd)
			stage_vld <= '0;
		else if (advance)
			stage_vld <= {stage_vld[3:0], 1'b1};
	end

	//////////////////////////////////////////////////////////////
	// Channels, each fed with the other's half sum
	//////////////////////////////////////////////////////////////

	aud_mix_chan chan_l_i (
		.clk       (clk),
		.resetd    (resetd),
		.i_advance (advance),
		.i_core    (i_core.left),
		.i_signed  (i_signed),
		.i_linux   (i_linux_l),
		.i_pre     (pre_r),
		.i_cfg     (i_cfg),
		.o_pre     (pre_l),
		.o_out     (out_l)
	);

	aud_mix_chan chan_r_i (
		.clk       (clk),
		.resetd    (resetd),
		.i_advance (advance),
		.i_core    (i_core.right),
		.i_signed  (i_signed),
		.i_linux   (i_linux_r),
		.i_pre     (pre_l),
		.i_cfg     (i_cfg),
		.o_pre     (pre_r),
		.o_out     (out_r)
	);

	// Output stage drives the stream
	assign out_smp         = '{left: out_l, right: out_r};
	assign o_stream.valid  = stage_vld[4];
	assign o_stream.left   = out_smp.left;
	assign o_stream.right  = out_smp.right;

endmodule

// ==== sys_cfg_pkg.sv ====
// Host configuration definitions
package sys_cfg_pkg;

	import audio_pkg::mix_mode_t;

	// Host bus word
	typedef logic [15:0] host_word_t;

	// Command codes carried in the low byte of the first word
	localparam logic [7:0] CMD_LED    = 8'h25;
	localparam logic [7:0] CMD_VOLUME = 8'h26;

	// Main board LED byte
	typedef logic [7:0] led_byte_t;

	// Status bits from the core and the video PLL
	typedef struct packed {
		logic       led_user;
		logic [1:0] led_power;
		logic [1:0] led_disk;
		logic       pll_locked;
	} led_status_t;

	// Mixer settings, att[4] mutes and att[3:0] is the shift
	typedef struct packed {
		logic [4:0] att;
		mix_mode_t  mode;
	} mix_cfg_t;

endpackage

// ==== sys_io_top.sv ====
// Board audio and LED system top
module sys_io_top
	import audio_pkg::*;
	import sys_cfg_pkg::*;
#(
	parameter int FILTER_DEPTH = 2
) (
	input  logic       clk,
	input  logic       resetd,

	// Host bus
	input  logic       i_host_sel,
	input  logic       i_host_strobe,
	input  host_word_t i_host_data,

	// Core and Linux audio
	input  sample_t    i_core_l,
	input  sample_t    i_core_r,
	input  sample_t    i_linux_l,
	input  sample_t    i_linux_r,
	input  logic       i_core_signed,

	// Status for the LEDs
	input  logic       i_led_user,
	input  logic       i_pll_locked,
	input  logic [1:0] i_led_power,
	input  logic [1:0] i_led_disk,
	output led_byte_t  o_led,

	// Mixed audio stream
	input  logic       i_aud_ready,
	output logic       o_aud_valid,
	output sample_t    o_aud_l,
	output sample_t    o_aud_r
);

	mix_cfg_t    mix_cfg;
	led_byte_t   led_mask;
	led_byte_t   led_state;
	core_audio_t core_raw;
	core_audio_t core_flt;
	led_status_t status_raw;
	led_status_t status_flt;

	audio_stream_if aud_if ();

	//////////////////////////////////////////////////////////////
	// Configuration and LEDs
	//////////////////////////////////////////////////////////////

	host_cmd_regs host_cmd_regs_i (
		.clk         (clk),
		.resetd      (resetd),
		.i_sel       (i_host_sel),
		.i_strobe    (i_host_strobe),
		.i_data      (i_host_data),
		.o_mix_cfg   (mix_cfg),
		.o_led_mask  (led_mask),
		.o_led_state (led_state)
	);

	assign status_raw = '{led_user: i_led_user, led_power: i_led_power,
		led_disk: i_led_disk, pll_locked: i_pll_locked};

	stable_filter #(.T(led_status_t), .FILTER_DEPTH(FILTER_DEPTH)) status_filt_i (
		.clk     (clk),
		.resetd  (resetd),
		.i_value (status_raw),
		.o_value (status_flt)
	);

	led_compositor led_compositor_i (
		.clk      (clk),
		.resetd   (resetd),
		.i_status (status_flt),
		.i_mask   (led_mask),
		.i_state  (led_state),
		.o_led    (o_led)
	);

	//////////////////////////////////////////////////////////////
	// Audio path
	//////////////////////////////////////////////////////////////

	assign core_raw = '{left: i_core_l, right: i_core_r};

	stable_filter #(.T(core_audio_t), .FILTER_DEPTH(FILTER_DEPTH)) core_filt_i (
		.clk     (clk),
		.resetd  (resetd),
		.i_value (core_raw),
		.o_value (core_flt)
	);

	stereo_mixer stereo_mixer_i (
		.clk       (clk),
		.resetd    (resetd),
		.i_core    (core_flt),
		.i_signed  (i_core_signed),
		.i_linux_l (i_linux_l),
		.i_linux_r (i_linux_r),
		.i_cfg     (mix_cfg),
		.o_stream  (aud_if)
	);

	assign aud_if.ready = i_aud_ready;
	assign o_aud_valid  = aud_if.valid;
	assign o_aud_l      = aud_if.left;
	assign o_aud_r      = aud_if.right;

endmodule

// ==== tb_sys_io_top.sv ====
// Testbench for the board audio and LED top
module tb_sys_io_top
	import audio_pkg::*;
	import sys_cfg_pkg::*;
();

	localparam int FILTER_DEPTH = 2;
	localparam int NUM_ROWS     = 12;
	localparam int TIMEOUT      = 2000;

	// One mixing case with its expected output pair
	typedef struct packed {
		sample_t    core_l;
		sample_t    core_r;
		logic       sgn;
		sample_t    linux_l;
		sample_t    linux_r;
		host_word_t vol;
		logic [1:0] rdy;
		sample_t    exp_l;
		sample_t    exp_r;
	} stim_row_t;

	logic        clk = 1'b0;
	logic        resetd;
	logic        i_host_sel;
	logic        i_host_strobe;
	host_word_t  i_host_data;
	sample_t     i_core_l;
	sample_t     i_core_r;
	sample_t     i_linux_l;
	sample_t     i_linux_r;
	logic        i_core_signed;
	logic        i_led_user;
	logic        i_pll_locked;
	logic [1:0]  i_led_power;
	logic [1:0]  i_led_disk;
	logic        i_aud_ready;
	led_byte_t   o_led;
	logic        o_aud_valid;
	sample_t     o_aud_l;
	sample_t     o_aud_r;

	stim_row_t   rows [NUM_ROWS];
	string       row_names [NUM_ROWS];
	logic [31:0] rand_state = 32'd52636;
	logic [31:0] r1;
	logic [31:0] r2;
	logic [31:0] r3;
	logic [31:0] r4;
	int          checks;
	int          mismatches;
	int          timeouts;
	int          stall_len;
	int          wait_cycles;
	sample_t     got_l;
	sample_t     got_r;
	sample_t     held_l;
	sample_t     held_r;
	led_byte_t   led_exp;

	sys_io_top #(.FILTER_DEPTH(FILTER_DEPTH)) sys_io_top_i (.*);

	always #4 clk = ~clk;

	//////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_random();
		rand_state = rand_state * 32'd1103515245 + 32'd12345;
		return rand_state;
	endfunction

	// Core plus Linux sum of one channel before cross-feed
	function automatic int chan_sum(input sample_t core, input logic sgn, input sample_t lnx);
		int c;
		if (sgn)
			c = int'($signed(core));
		else
			c = int'(core) >>> 1;
		return c + int'($signed(lnx));
	endfunction

	// Other channel contributes half of its sum
	function automatic sample_t mix_model(input int sum, input int other_sum, input host_word_t vol);
		int pre;
		int m;
		int a;
		pre = other_sum >>> 1;
		case (vol[9:8])
			2'd1:    m = sum - (sum >>> 3) + (pre >>> 2);
			2'd2:    m = sum - (sum >>> 2) + (pre >>> 1);
			2'd3:    m = (sum >>> 1) + pre;
			default: m = sum;
		endcase
		a = vol[4] ? 0 : (m >>> vol[3:0]);
		if (a > 32767)
			a = 32767;
		else if (a < -32768)
			a = -32768;
		return a[15:0];
	endfunction

	function automatic led_byte_t led_expect(input logic user, input logic pll,
			input logic [1:0] pwr, input logic [1:0] disk, input led_byte_t mask,
			input led_byte_t state);
		led_byte_t pat;
		pat    = 8'h00;
		pat[6] = pll;
		pat[4] = pwr[1] ? pwr[0] : 1'b1;
		pat[2] = disk[0];
		pat[0] = user;
		for (int b = 0; b < 8; b++) begin
			if (mask[b])
				pat[b] = state[b];
		end
		return pat;
	endfunction

	//////////////////////////////////////////////////////////////
	// Checks and bus tasks
	//////////////////////////////////////////////////////////////

	task automatic check_equal(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		checks++;
		if (expected !== actual) begin
			mismatches++;
			$display("FAIL %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic set_row(input int idx, input string name, input sample_t cl, input sample_t cr,
			input logic sgn, input sample_t ll, input sample_t lr, input host_word_t vol,
			input logic [1:0] rdy);
		int sum_l;
		int sum_r;
		sum_l = chan_sum(cl, sgn, ll);
		sum_r = chan_sum(cr, sgn, lr);
		row_names[idx] = name;
		rows[idx] = '{cl, cr, sgn, ll, lr, vol, rdy,
			mix_model(sum_l, sum_r, vol), mix_model(sum_r, sum_l, vol)};
	endtask

	// Command word followed by one data word in the same frame
	task automatic host_write(input logic [7:0] cmd, input host_word_t word);
		@(posedge clk);
		i_host_sel <= 1'b1;
		@(posedge clk);
		i_host_strobe <= 1'b1;
		i_host_data   <= {8'h00, cmd};
		@(posedge clk);
		i_host_data <= word;
		@(posedge clk);
		i_host_strobe <= 1'b0;
		@(posedge clk);
		i_host_sel <= 1'b0;
	endtask

	// Ready pattern 0 is always high, 1 alternates, 2 is random
	task automatic accept_samples(input int n, input logic [1:0] rdy,
			output sample_t last_l, output sample_t last_r);
		int          got;
		int          cycles;
		logic [31:0] r;
		got    = 0;
		cycles = 0;
		last_l = '0;
		last_r = '0;
		while (got < n && cycles < TIMEOUT) begin
			r = next_random();
			@(posedge clk);
			case (rdy)
				2'd1:    i_aud_ready <= cycles[0];
				2'd2:    i_aud_ready <= r[20];
				default: i_aud_ready <= 1'b1;
			endcase
			@(negedge clk);
			if (o_aud_valid && i_aud_ready) begin
				got++;
				last_l = o_aud_l;
				last_r = o_aud_r;
			end
			cycles++;
		end
		if (got < n) begin
			timeouts++;
			$display("Timeout: only %0d of %0d samples were accepted", got, n);
		end
	endtask

	task automatic wait_led(input string name, input led_byte_t expected);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (o_led !== expected && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (o_led !== expected) begin
			timeouts++;
			$display("Timeout: the LED byte never settled in %s", name);
		end
		check_equal(name, {8'h00, expected}, {8'h00, o_led});
	endtask

	//////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////

	initial begin
		resetd        <= 1'b1;
		i_host_sel    <= 1'b0;
		i_host_strobe <= 1'b0;
		i_host_data   <= '0;
		i_core_l      <= '0;
		i_core_r      <= '0;
		i_linux_l     <= '0;
		i_linux_r     <= '0;
		i_core_signed <= 1'b1;
		i_led_user    <= 1'b1;
		i_pll_locked  <= 1'b1;
		i_led_power   <= 2'b10;
		i_led_disk    <= 2'b01;
		i_aud_ready   <= 1'b1;
		checks     = 0;
		mismatches = 0;
		timeouts   = 0;

		set_row(0, "none_signed", 16'h03E8, 16'hF830, 1'b1, 16'h012C, 16'h0190, 16'h0000, 2'd0);
		set_row(1, "none_unsigned", 16'hC000, 16'h4000, 1'b0, 16'h0100, 16'hFF00, 16'h0000, 2'd1);
		set_row(2, "low_mode", 16'h1200, 16'hE400, 1'b1, 16'h0800, 16'hF000, 16'h0100, 2'd0);
		set_row(3, "mid_mode", 16'h2000, 16'h0400, 1'b1, 16'hF800, 16'h1000, 16'h0200, 2'd1);
		set_row(4, "mono_mode", 16'hA000, 16'h3000, 1'b0, 16'h0200, 16'h0600, 16'h0300, 2'd2);
		set_row(5, "mute", 16'h3000, 16'hC000, 1'b1, 16'h1000, 16'h2000, 16'h0310, 2'd0);
		set_row(6, "att_shift3", 16'h4000, 16'hB000, 1'b1, 16'h1000, 16'hF000, 16'h0003, 2'd1);
		set_row(7, "sat_pos", 16'h7000, 16'h7FFF, 1'b1, 16'h7000, 16'h6000, 16'h0000, 2'd0);
		set_row(8, "sat_neg", 16'h8000, 16'h9000, 1'b1, 16'h8000, 16'hA000, 16'h0000, 2'd2);
		for (int i = 9; i < NUM_ROWS; i++) begin
			r1 = next_random();
			r2 = next_random();
			r3 = next_random();
			r4 = next_random();
			set_row(i, $sformatf("random_%0d", i), r1[31:16], r2[31:16], r3[27],
				r3[31:16], r4[31:16], {6'h00, r4[25:24], 6'h00, r4[29:28]}, 2'd2);
		end

		// Stream stays idle through reset
		for (int k = 0; k < 4; k++) begin
			@(negedge clk);
			check_equal("valid_in_reset", 16'h0000, {15'h0, o_aud_valid});
		end
		@(posedge clk);
		resetd <= 1'b0;

		// Pipeline is still filling after release
		@(posedge clk);
		for (int k = 0; k < 3; k++) begin
			@(negedge clk);
			check_equal("valid_after_reset", 16'h0000, {15'h0, o_aud_valid});
		end

		// LED pattern and host override
		wait_led("led_reset", led_expect(1'b1, 1'b1, 2'b10, 2'b01, 8'h00, 8'h00));
		@(posedge clk);
		i_led_power <= 2'b00;
		i_led_disk  <= 2'b10;
		wait_led("led_status", led_expect(1'b1, 1'b1, 2'b00, 2'b10, 8'h00, 8'h00));
		host_write(CMD_LED, 16'hF0A5);
		led_exp = led_expect(1'b1, 1'b1, 2'b00, 2'b10, 8'hF0, 8'hA5);
		wait_led("led_override", led_exp);

		// Strobes without select and then an unknown command
		@(posedge clk);
		i_host_strobe <= 1'b1;
		i_host_data   <= 16'h0025;
		@(posedge clk);
		i_host_data <= 16'h00FF;
		@(posedge clk);
		i_host_strobe <= 1'b0;
		host_write(8'h33, 16'hFFFF);
		for (int k = 0; k < 4; k++)
			@(posedge clk);
		@(negedge clk);
		check_equal("led_ignored", {8'h00, led_exp}, {8'h00, o_led});
		host_write(CMD_LED, 16'h0000);
		wait_led("led_released", led_expect(1'b1, 1'b1, 2'b00, 2'b10, 8'h00, 8'h00));

		// Mixing table
		for (int i = 0; i < NUM_ROWS; i++) begin
			host_write(CMD_VOLUME, rows[i].vol);
			@(posedge clk);
			i_core_l      <= rows[i].core_l;
			i_core_r      <= rows[i].core_r;
			i_core_signed <= rows[i].sgn;
			i_linux_l     <= rows[i].linux_l;
			i_linux_r     <= rows[i].linux_r;
			accept_samples(16, rows[i].rdy, got_l, got_r);
			check_equal({row_names[i], "_left"}, rows[i].exp_l, got_l);
			check_equal({row_names[i], "_right"}, rows[i].exp_r, got_r);
		end

		// Back-pressure with a stall of random length
		r1 = next_random();
		stall_len = 3 + int'(r1[20:16]);
		accept_samples(8, 2'd0, got_l, got_r);

		// Distinct Linux samples so that each stage holds a different value
		for (int k = 0; k < 6; k++) begin
			r2 = next_random();
			r3 = next_random();
			@(posedge clk);
			i_linux_l <= r2[31:16];
			i_linux_r <= r3[31:16];
		end
		@(posedge clk);
		i_aud_ready <= 1'b0;
		i_linux_l   <= rows[NUM_ROWS-1].linux_l;
		i_linux_r   <= rows[NUM_ROWS-1].linux_r;
		wait_cycles = 0;
		@(negedge clk);
		while (o_aud_valid !== 1'b1 && wait_cycles < TIMEOUT) begin
			@(negedge clk);
			wait_cycles++;
		end
		if (o_aud_valid !== 1'b1) begin
			timeouts++;
			$display("Timeout: no valid sample appeared before the stall");
		end
		held_l = o_aud_l;
		held_r = o_aud_r;
		for (int k = 0; k < stall_len; k++) begin
			@(negedge clk);
			check_equal("stall_valid", 16'h0001, {15'h0, o_aud_valid});
			check_equal("stall_left", held_l, o_aud_l);
			check_equal("stall_right", held_r, o_aud_r);
		end
		accept_samples(1, 2'd0, got_l, got_r);
		check_equal("held_left", held_l, got_l);
		check_equal("held_right", held_r, got_r);
		accept_samples(16, 2'd2, got_l, got_r);
		check_equal("resume_left", rows[NUM_ROWS-1].exp_l, got_l);
		check_equal("resume_right", rows[NUM_ROWS-1].exp_r, got_r);

		$display("Checks: %0d  mismatches: %0d  timeouts: %0d", checks, mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule
